/* compile.f */
logic/mem_stage_pkg.sv
logic/lsu_lane.sv
logic/mem_port_arbiter.sv
logic/data_ram.sv
logic/memory_stage.sv
logic/mem_subsystem.sv
verif/mem_subsystem_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module mem_subsystem_tb \
    -f compile.f \
    -o sim_mem_subsystem
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_mem_subsystem
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi
exit 0

/* verif/mem_subsystem_tb.sv */
`timescale 1ns/100ps

module mem_subsystem_tb;
    import mem_stage_pkg::*;

    localparam int ram_words = 256;
    localparam int model_bytes = ram_words * 4;
    localparam int byte_bits = $clog2(model_bytes);
    localparam int n_alu = 40;
    localparam int n_mem = 100;
    localparam int n_conflict = 40;
    localparam int n_fence = 20;
    localparam int n_clear = 20;
    localparam int total_pairs = n_alu + 2 * (n_mem + n_conflict + n_fence + n_clear);
    localparam int test_cycles = 20 + 2 * total_pairs;   // a conflict pair takes two.
    localparam int watchdog_ns = test_cycles * 10 + 1000;

    logic clock = 1'b0;
    logic reset;
    logic clear;
    mem_op_t issue_op_0, issue_op_1;
    access_size_t issue_size_0, issue_size_1;
    logic issue_unsigned_0, issue_unsigned_1;
    addr_t issue_addr_0, issue_addr_1;
    data_t issue_data_0, issue_data_1;
    reg_addr_t issue_waddr_0, issue_waddr_1;
    logic stall;
    logic wb_wren_0, wb_wren_1, fwd_wren_0, fwd_wren_1;
    reg_addr_t wb_waddr_0, wb_waddr_1, fwd_waddr_0, fwd_waddr_1;
    data_t wb_wdata_0, wb_wdata_1, fwd_wdata_0, fwd_wdata_1;

    integer seed = 50085;
    logic [7:0] model_mem [model_bytes];   // byte image of the data memory.

    // pair presented to the stage with one entry per lane.
    mem_op_t lane_op [2];
    access_size_t lane_size [2];
    logic lane_uns [2];
    addr_t lane_addr [2];
    data_t lane_data [2];
    reg_addr_t lane_waddr [2];
    logic lane_clear;

    logic exp_wren [2];
    data_t exp_wdata [2];
    int exp_stall_cycles;

    mem_subsystem #(
        .ram_words(ram_words)
    ) mem_subsystem_i (
        .clock(clock), .reset(reset), .clear(clear),
        .issue_op_0(issue_op_0), .issue_op_1(issue_op_1),
        .issue_size_0(issue_size_0), .issue_size_1(issue_size_1),
        .issue_unsigned_0(issue_unsigned_0), .issue_unsigned_1(issue_unsigned_1),
        .issue_addr_0(issue_addr_0), .issue_addr_1(issue_addr_1),
        .issue_data_0(issue_data_0), .issue_data_1(issue_data_1),
        .issue_waddr_0(issue_waddr_0), .issue_waddr_1(issue_waddr_1),
        .stall(stall),
        .wb_wren_0(wb_wren_0), .wb_wren_1(wb_wren_1),
        .wb_waddr_0(wb_waddr_0), .wb_waddr_1(wb_waddr_1),
        .wb_wdata_0(wb_wdata_0), .wb_wdata_1(wb_wdata_1),
        .fwd_wren_0(fwd_wren_0), .fwd_wren_1(fwd_wren_1),
        .fwd_waddr_0(fwd_waddr_0), .fwd_waddr_1(fwd_waddr_1),
        .fwd_wdata_0(fwd_wdata_0), .fwd_wdata_1(fwd_wdata_1)
    );

    always #5 clock = ~clock;

    initial begin
        #(watchdog_ns);
        $display("watchdog expired before the tests finished");
        $display("Testbench failed");
        $fatal(1);
    end

    task automatic check_word(input string name, input data_t expected, input data_t actual);
        assert (actual === expected) else begin
            $display("error: %s expected %h got %h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        assert (actual === expected) else begin
            $display("error: %s expected %h got %h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic addr_t align(input addr_t a, input access_size_t sz);
        case (sz)
            size_byte: return a;
            size_half: return {a[31:1], 1'b0};
            default: return {a[31:2], 2'b00};
        endcase
    endfunction

    // low window keeps accesses overlapping and upper bits test the wrap.
    function automatic addr_t random_addr(input access_size_t sz);
        addr_t a;
        a = rand_word();
        a[byte_bits-1:6] = '0;
        return align(a, sz);
    endfunction

    function automatic access_size_t random_size();
        logic [31:0] r;
        r = rand_word();
        case (r[1:0])
            2'd0: return size_byte;
            2'd1: return size_half;
            default: return size_word;
        endcase
    endfunction

    function automatic int byte_index(input addr_t a);
        return int'(a[byte_bits-1:0]);
    endfunction

    // little endian with sign or zero extension.
    function automatic data_t load_value(input addr_t a, input access_size_t sz, input logic uns);
        int base;
        data_t w;
        base = byte_index(a);
        case (sz)
            size_byte: begin
                w = {24'h000000, model_mem[base]};
                if (!uns && w[7]) w[31:8] = 24'hffffff;
            end
            size_half: begin
                base = base & ~1;
                w = {16'h0000, model_mem[base+1], model_mem[base]};
                if (!uns && w[15]) w[31:16] = 16'hffff;
            end
            default: begin
                base = base & ~3;
                w = {model_mem[base+3], model_mem[base+2], model_mem[base+1], model_mem[base]};
            end
        endcase
        return w;
    endfunction

    function automatic void store_value(input addr_t a, input access_size_t sz, input data_t d);
        int base;
        int count;
        base = byte_index(a);
        case (sz)
            size_byte: count = 1;
            size_half: begin
                base = base & ~1;
                count = 2;
            end
            default: begin
                base = base & ~3;
                count = 4;
            end
        endcase
        for (int i = 0; i < count; i++) begin
            model_mem[base+i] = d[8*i +: 8];
        end
    endfunction

    function automatic logic is_mem(input mem_op_t op);
        return (op == op_load) || (op == op_store);
    endfunction

    function automatic void idle_pair();
        lane_clear = 1'b0;
        for (int l = 0; l < 2; l++) begin
            lane_op[l] = op_none;
            lane_size[l] = size_word;
            lane_uns[l] = 1'b0;
            lane_addr[l] = '0;
            lane_data[l] = '0;
            lane_waddr[l] = '0;
        end
    endfunction

    function automatic void random_lane(input int l, input mem_op_t op);
        logic [31:0] r;
        r = rand_word();
        lane_op[l] = op;
        lane_size[l] = random_size();
        lane_uns[l] = r[5];
        lane_addr[l] = random_addr(lane_size[l]);
        lane_data[l] = rand_word();
        lane_waddr[l] = r[4:0];
    endfunction

    function automatic void drive_inputs();
        clear = lane_clear;
        issue_op_0 = lane_op[0];
        issue_op_1 = lane_op[1];
        issue_size_0 = lane_size[0];
        issue_size_1 = lane_size[1];
        issue_unsigned_0 = lane_uns[0];
        issue_unsigned_1 = lane_uns[1];
        issue_addr_0 = lane_addr[0];
        issue_addr_1 = lane_addr[1];
        issue_data_0 = lane_data[0];
        issue_data_1 = lane_data[1];
        issue_waddr_0 = lane_waddr[0];
        issue_waddr_1 = lane_waddr[1];
    endfunction

    // lane 0 before lane 1 so the model sees stores in order.
    function automatic void predict_pair();
        logic live [2];
        live[0] = !lane_clear;
        live[1] = !lane_clear && (lane_op[0] != op_fence);
        exp_stall_cycles = (live[0] && live[1] && is_mem(lane_op[0]) && is_mem(lane_op[1]))
                           ? 1 : 0;
        for (int l = 0; l < 2; l++) begin
            exp_wren[l] = 1'b0;
            exp_wdata[l] = lane_data[l];
            if (live[l]) begin
                case (lane_op[l])
                    op_alu: exp_wren[l] = (lane_waddr[l] != '0);
                    op_load: begin
                        exp_wren[l] = (lane_waddr[l] != '0);
                        exp_wdata[l] = load_value(lane_addr[l], lane_size[l], lane_uns[l]);
                    end
                    op_store: store_value(lane_addr[l], lane_size[l], lane_data[l]);
                    default: ;
                endcase
            end
        end
    endfunction

    task automatic check_port(input string kind, input int lane, input logic wren,
                              input reg_addr_t waddr, input data_t wdata);
        check_bit($sformatf("%s_wren_%0d", kind, lane), exp_wren[lane], wren);
        if (exp_wren[lane]) begin
            check_word($sformatf("%s_waddr_%0d", kind, lane), 32'(lane_waddr[lane]), 32'(waddr));
            check_word($sformatf("%s_wdata_%0d", kind, lane), exp_wdata[lane], wdata);
        end
    endtask

    // pair held while stalled for a bounded number of cycles.
    task automatic run_pair();
        int stalls;
        @(negedge clock);
        drive_inputs();
        predict_pair();
        stalls = 0;
        #2;
        while (stall && stalls < 4) begin
            check_bit("fwd_wren_0", 1'b0, fwd_wren_0);
            check_bit("fwd_wren_1", 1'b0, fwd_wren_1);
            stalls++;
            @(negedge clock);
            #2;
        end
        check_word("stall cycles", exp_stall_cycles, stalls);
        check_port("fwd", 0, fwd_wren_0, fwd_waddr_0, fwd_wdata_0);
        check_port("fwd", 1, fwd_wren_1, fwd_waddr_1, fwd_wdata_1);
        @(posedge clock);
        #1;
        check_port("wb", 0, wb_wren_0, wb_waddr_0, wb_wdata_0);
        check_port("wb", 1, wb_wren_1, wb_waddr_1, wb_wdata_1);
    endtask

    initial begin
        logic [31:0] r;
        addr_t a0;
        addr_t a1;
        access_size_t sz;
        int st;
        int ld;
        reset = 1'b0;
        for (int i = 0; i < model_bytes; i++) begin
            model_mem[i] = 8'h00;
        end
        idle_pair();
        drive_inputs();
        repeat (16) begin
            @(negedge clock);
            check_bit("stall", 1'b0, stall);
            check_bit("wb_wren_0", 1'b0, wb_wren_0);
            check_bit("wb_wren_1", 1'b0, wb_wren_1);
        end
        reset = 1'b1;
        repeat (4) begin
            @(negedge clock);
            check_bit("stall", 1'b0, stall);
            check_bit("wb_wren_0", 1'b0, wb_wren_0);
            check_bit("wb_wren_1", 1'b0, wb_wren_1);
        end

        for (int i = 0; i < n_alu; i++) begin
            idle_pair();
            random_lane(0, op_alu);
            random_lane(1, op_alu);
            if (i % 4 == 0) lane_waddr[0] = '0;   // x0 target.
            if (i % 4 == 1) lane_waddr[1] = '0;
            run_pair();
        end

        // store and then load it back in either lane.
        for (int i = 0; i < n_mem; i++) begin
            r = rand_word();
            st = int'(r[0]);
            ld = int'(r[1]);
            idle_pair();
            random_lane(st, op_store);
            random_lane(1 - st, op_alu);
            run_pair();
            a0 = lane_addr[st];
            idle_pair();
            random_lane(ld, op_load);
            lane_addr[ld] = align(a0, lane_size[ld]);
            random_lane(1 - ld, op_alu);
            run_pair();
        end

        for (int i = 0; i < n_conflict; i++) begin
            r = rand_word();
            idle_pair();
            random_lane(0, r[0] ? op_store : op_load);
            random_lane(1, r[1] ? op_store : op_load);
            run_pair();
            a0 = lane_addr[0];
            sz = lane_size[0];
            idle_pair();
            random_lane(1, op_load);
            lane_size[1] = sz;
            lane_addr[1] = a0;
            run_pair();
        end

        for (int i = 0; i < n_fence; i++) begin
            idle_pair();
            random_lane(0, op_fence);
            random_lane(1, (i % 2 == 0) ? op_store : op_alu);
            lane_waddr[1] = lane_waddr[1] | 5'd1;
            run_pair();
            a1 = lane_addr[1];
            idle_pair();
            random_lane(0, op_load);
            lane_size[0] = size_word;
            lane_addr[0] = align(a1, size_word);
            lane_waddr[0] = lane_waddr[0] | 5'd1;
            run_pair();
        end

        for (int i = 0; i < n_clear; i++) begin
            r = rand_word();
            idle_pair();
            random_lane(0, r[0] ? op_store : op_alu);
            random_lane(1, r[1] ? op_store : op_load);
            lane_clear = 1'b1;
            run_pair();
            a0 = lane_addr[0];
            a1 = lane_addr[1];
            idle_pair();
            random_lane(0, op_load);
            lane_size[0] = size_word;
            lane_addr[0] = align(a0, size_word);
            random_lane(1, op_load);
            lane_size[1] = size_word;
            lane_addr[1] = align(a1, size_word);
            run_pair();
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

/* logic/mem_subsystem.sv */
`timescale 1ns/100ps

module mem_subsystem #(
    parameter int ram_words = 256
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        clear,
    input  mem_stage_pkg::mem_op_t      issue_op_0,
    input  mem_stage_pkg::mem_op_t      issue_op_1,
    input  mem_stage_pkg::access_size_t issue_size_0,
    input  mem_stage_pkg::access_size_t issue_size_1,
    input  logic                        issue_unsigned_0,
    input  logic                        issue_unsigned_1,
    input  mem_stage_pkg::addr_t        issue_addr_0,
    input  mem_stage_pkg::addr_t        issue_addr_1,
    input  mem_stage_pkg::data_t        issue_data_0,
    input  mem_stage_pkg::data_t        issue_data_1,
    input  mem_stage_pkg::reg_addr_t    issue_waddr_0,
    input  mem_stage_pkg::reg_addr_t    issue_waddr_1,
    output logic                        stall,
    output logic                        wb_wren_0,
    output logic                        wb_wren_1,
    output mem_stage_pkg::reg_addr_t    wb_waddr_0,
    output mem_stage_pkg::reg_addr_t    wb_waddr_1,
    output mem_stage_pkg::data_t        wb_wdata_0,
    output mem_stage_pkg::data_t        wb_wdata_1,
    output logic                        fwd_wren_0,
    output logic                        fwd_wren_1,
    output mem_stage_pkg::reg_addr_t    fwd_waddr_0,
    output mem_stage_pkg::reg_addr_t    fwd_waddr_1,
    output mem_stage_pkg::data_t        fwd_wdata_0,
    output mem_stage_pkg::data_t        fwd_wdata_1
);
    import mem_stage_pkg::*;

    logic    req_0;
    logic    req_1;
    logic    grant_0;
    logic    grant_1;
    logic    req_write_0;
    logic    req_write_1;
    data_t   req_wdata_0;
    data_t   req_wdata_1;
    strobe_t req_strobe_0;
    strobe_t req_strobe_1;
    data_t   load_data_0;
    data_t   load_data_1;
    logic    ram_write;
    addr_t   ram_addr;
    data_t   ram_wdata;
    strobe_t ram_strobe;
    data_t   ram_rdata;

    memory_stage memory_stage_i (
        .clock(clock),
        .reset(reset),
        .clear(clear),
        .issue_op_0(issue_op_0),
        .issue_op_1(issue_op_1),
        .issue_size_0(issue_size_0),
        .issue_size_1(issue_size_1),
        .issue_unsigned_0(issue_unsigned_0),
        .issue_unsigned_1(issue_unsigned_1),
        .issue_addr_0(issue_addr_0),
        .issue_addr_1(issue_addr_1),
        .issue_data_0(issue_data_0),
        .issue_data_1(issue_data_1),
        .issue_waddr_0(issue_waddr_0),
        .issue_waddr_1(issue_waddr_1),
        .grant_0(grant_0),
        .grant_1(grant_1),
        .load_data_0(load_data_0),
        .load_data_1(load_data_1),
        .req_0(req_0),
        .req_1(req_1),
        .stall(stall),
        .wb_wren_0(wb_wren_0),
        .wb_wren_1(wb_wren_1),
        .wb_waddr_0(wb_waddr_0),
        .wb_waddr_1(wb_waddr_1),
        .wb_wdata_0(wb_wdata_0),
        .wb_wdata_1(wb_wdata_1),
        .fwd_wren_0(fwd_wren_0),
        .fwd_wren_1(fwd_wren_1),
        .fwd_waddr_0(fwd_waddr_0),
        .fwd_waddr_1(fwd_waddr_1),
        .fwd_wdata_0(fwd_wdata_0),
        .fwd_wdata_1(fwd_wdata_1)
    );

    // both lanes see the same port word.
    lsu_lane lsu_lane_0_i (
        .issue_op(issue_op_0),
        .issue_size(issue_size_0),
        .issue_unsigned(issue_unsigned_0),
        .issue_addr(issue_addr_0),
        .issue_data(issue_data_0),
        .mem_rdata(ram_rdata),
        .req_write(req_write_0),
        .req_wdata(req_wdata_0),
        .req_strobe(req_strobe_0),
        .load_data(load_data_0)
    );

    lsu_lane lsu_lane_1_i (
        .issue_op(issue_op_1),
        .issue_size(issue_size_1),
        .issue_unsigned(issue_unsigned_1),
        .issue_addr(issue_addr_1),
        .issue_data(issue_data_1),
        .mem_rdata(ram_rdata),
        .req_write(req_write_1),
        .req_wdata(req_wdata_1),
        .req_strobe(req_strobe_1),
        .load_data(load_data_1)
    );

    mem_port_arbiter mem_port_arbiter_i (
        .clock(clock),
        .reset(reset),
        .req_0(req_0),
        .req_1(req_1),
        .write_0(req_write_0),
        .write_1(req_write_1),
        .addr_0(issue_addr_0),
        .addr_1(issue_addr_1),
        .wdata_0(req_wdata_0),
        .wdata_1(req_wdata_1),
        .strobe_0(req_strobe_0),
        .strobe_1(req_strobe_1),
        .grant_0(grant_0),
        .grant_1(grant_1),
        .ram_write(ram_write),
        .ram_addr(ram_addr),
        .ram_wdata(ram_wdata),
        .ram_strobe(ram_strobe)
    );

    data_ram #(
        .ram_words(ram_words)
    ) data_ram_i (
        .clock(clock),
        .reset(reset),
        .write(ram_write),
        .addr(ram_addr),
        .wdata(ram_wdata),
        .strobe(ram_strobe),
        .rdata(ram_rdata)
    );

endmodule

/* logic/memory_stage.sv */
`timescale 1ns/100ps

module memory_stage (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        clear,
    input  mem_stage_pkg::mem_op_t      issue_op_0,
    input  mem_stage_pkg::mem_op_t      issue_op_1,
    input  mem_stage_pkg::access_size_t issue_size_0,
    input  mem_stage_pkg::access_size_t issue_size_1,
    input  logic                        issue_unsigned_0,
    input  logic                        issue_unsigned_1,
    input  mem_stage_pkg::addr_t        issue_addr_0,
    input  mem_stage_pkg::addr_t        issue_addr_1,
    input  mem_stage_pkg::data_t        issue_data_0,
    input  mem_stage_pkg::data_t        issue_data_1,
    input  mem_stage_pkg::reg_addr_t    issue_waddr_0,
    input  mem_stage_pkg::reg_addr_t    issue_waddr_1,
    input  logic                        grant_0,
    input  logic                        grant_1,
    input  mem_stage_pkg::data_t        load_data_0,
    input  mem_stage_pkg::data_t        load_data_1,
    output logic                        req_0,
    output logic                        req_1,
    output logic                        stall,
    output logic                        wb_wren_0,
    output logic                        wb_wren_1,
    output mem_stage_pkg::reg_addr_t    wb_waddr_0,
    output mem_stage_pkg::reg_addr_t    wb_waddr_1,
    output mem_stage_pkg::data_t        wb_wdata_0,
    output mem_stage_pkg::data_t        wb_wdata_1,
    output logic                        fwd_wren_0,
    output logic                        fwd_wren_1,
    output mem_stage_pkg::reg_addr_t    fwd_waddr_0,
    output mem_stage_pkg::reg_addr_t    fwd_waddr_1,
    output mem_stage_pkg::data_t        fwd_wdata_0,
    output mem_stage_pkg::data_t        fwd_wdata_1
);
    import mem_stage_pkg::*;

    logic  hold_valid;   // second cycle of a conflict.
    data_t hold_data;
    logic  squash_1;
    logic  mem_0;
    logic  mem_1;
    logic  wr_op_0;
    logic  wr_op_1;

    // a fence in lane 0 kills the younger lane.
    assign squash_1 = clear | (issue_op_0 == op_fence);

    assign mem_0 = (issue_op_0 == op_load) | (issue_op_0 == op_store);
    assign mem_1 = (issue_op_1 == op_load) | (issue_op_1 == op_store);
    assign wr_op_0 = (issue_op_0 == op_alu) | (issue_op_0 == op_load);
    assign wr_op_1 = (issue_op_1 == op_alu) | (issue_op_1 == op_load);

    assign req_0 = mem_0 & ~clear & ~hold_valid;   // lane 0 is not served twice.
    assign req_1 = mem_1 & ~squash_1;

    // both requests drop under clear, so stall does too.
    assign stall = (req_0 & ~grant_0) | (req_1 & ~grant_1);

    always_comb begin
        if (issue_op_0 == op_load) begin
            fwd_wdata_0 = hold_valid ? hold_data : load_data_0;
        end else begin
            fwd_wdata_0 = issue_data_0;
        end
        fwd_wdata_1 = (issue_op_1 == op_load) ? load_data_1 : issue_data_1;
    end

    assign fwd_waddr_0 = issue_waddr_0;
    assign fwd_waddr_1 = issue_waddr_1;

    // x0 never written.
    assign fwd_wren_0 = wr_op_0 & ~clear & ~stall & (issue_waddr_0 != '0);
    assign fwd_wren_1 = wr_op_1 & ~squash_1 & ~stall & (issue_waddr_1 != '0);

    always_ff @(posedge clock) begin
        if (!reset) begin
            hold_valid <= 1'b0;
            wb_wren_0 <= 1'b0;
            wb_wren_1 <= 1'b0;
        end else begin
            hold_valid <= stall;
            wb_wren_0 <= fwd_wren_0;
            wb_wren_1 <= fwd_wren_1;
        end
    end

    always_ff @(posedge clock) begin
        if (stall) begin
            hold_data <= load_data_0;   // lane 0 owns the port this cycle.
        end
        wb_waddr_0 <= fwd_waddr_0;
        wb_waddr_1 <= fwd_waddr_1;
        wb_wdata_0 <= fwd_wdata_0;
        wb_wdata_1 <= fwd_wdata_1;
    end

endmodule

/* logic/data_ram.sv */
`timescale 1ns/100ps

module data_ram #(
    parameter int ram_words = 256
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   write,
    input  mem_stage_pkg::addr_t   addr,
    input  mem_stage_pkg::data_t   wdata,
    input  mem_stage_pkg::strobe_t strobe,
    output mem_stage_pkg::data_t   rdata
);
    import mem_stage_pkg::*;

    localparam int index_bits = $clog2(ram_words);

    data_t                 mem [ram_words];
    logic [index_bits-1:0] index;

    assign index = addr[index_bits+1:2];   // byte offset dropped, upper bits wrap.
    assign rdata = mem[index];

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < ram_words; i++) begin
                mem[i] <= '0;
            end
        end else if (write) begin
            for (int b = 0; b < $bits(strobe_t); b++) begin
                if (strobe[b]) begin
                    mem[index][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

/* logic/mem_port_arbiter.sv */
`timescale 1ns/100ps

module mem_port_arbiter (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   req_0,
    input  logic                   req_1,
    input  logic                   write_0,
    input  logic                   write_1,
    input  mem_stage_pkg::addr_t   addr_0,
    input  mem_stage_pkg::addr_t   addr_1,
    input  mem_stage_pkg::data_t   wdata_0,
    input  mem_stage_pkg::data_t   wdata_1,
    input  mem_stage_pkg::strobe_t strobe_0,
    input  mem_stage_pkg::strobe_t strobe_1,
    output logic                   grant_0,
    output logic                   grant_1,
    output logic                   ram_write,
    output mem_stage_pkg::addr_t   ram_addr,
    output mem_stage_pkg::data_t   ram_wdata,
    output mem_stage_pkg::strobe_t ram_strobe
);

    logic served;   // lane 0 went first, lane 1 still owed the port.

    // fixed priority to the older lane.
    assign grant_0 = req_0 & ~served;
    assign grant_1 = req_1 & ~grant_0;

    assign ram_write = (grant_0 & write_0) | (grant_1 & write_1);
    assign ram_addr = grant_1 ? addr_1 : addr_0;
    assign ram_wdata = grant_1 ? wdata_1 : wdata_0;
    assign ram_strobe = grant_1 ? strobe_1 : strobe_0;

    // set on a conflict, gone once lane 1 has had its turn.
    always_ff @(posedge clock) begin
        if (!reset) begin
            served <= 1'b0;
        end else begin
            served <= grant_0 & req_1;
        end
    end

endmodule

/* logic/lsu_lane.sv */
`timescale 1ns/100ps

module lsu_lane (
    input  mem_stage_pkg::mem_op_t      issue_op,
    input  mem_stage_pkg::access_size_t issue_size,
    input  logic                        issue_unsigned,
    input  mem_stage_pkg::addr_t        issue_addr,
    input  mem_stage_pkg::data_t        issue_data,
    input  mem_stage_pkg::data_t        mem_rdata,
    output logic                        req_write,
    output mem_stage_pkg::data_t        req_wdata,
    output mem_stage_pkg::strobe_t      req_strobe,
    output mem_stage_pkg::data_t        load_data
);
    import mem_stage_pkg::*;

    logic [7:0]  load_byte;
    logic [15:0] load_half;
    strobe_t     size_strobe;

    assign req_write = (issue_op == op_store);

    // byte and halfword are replicated across the word.
    always_comb begin
        case (issue_size)
            size_byte: begin
                req_wdata = {4{issue_data[7:0]}};
                size_strobe = 4'b0001 << issue_addr[1:0];
            end
            size_half: begin
                req_wdata = {2{issue_data[15:0]}};
                size_strobe = issue_addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                req_wdata = issue_data;
                size_strobe = 4'b1111;
            end
        endcase
    end

    assign req_strobe = req_write ? size_strobe : '0;   // no byte enables for loads.

    assign load_byte = mem_rdata[{issue_addr[1:0], 3'b000} +: 8];
    assign load_half = mem_rdata[{issue_addr[1], 4'b0000} +: 16];   // rounded down.

    always_comb begin
        case (issue_size)
            size_byte: begin
                load_data = issue_unsigned ? {24'h000000, load_byte}
                                           : {{24{load_byte[7]}}, load_byte};
            end
            size_half: begin
                load_data = issue_unsigned ? {16'h0000, load_half}
                                           : {{16{load_half[15]}}, load_half};
            end
            default: begin
                load_data = mem_rdata;
            end
        endcase
    end

endmodule

/* logic/mem_stage_pkg.sv */
package mem_stage_pkg;

    localparam int data_width = 32;
    localparam int addr_width = 32;
    localparam int reg_addr_width = 5;
    localparam int strobe_width = data_width / 8;

    typedef logic [data_width-1:0] data_t;
    typedef logic [addr_width-1:0] addr_t;
    typedef logic [reg_addr_width-1:0] reg_addr_t;
    typedef logic [strobe_width-1:0] strobe_t;   // one enable per byte.

    // operation carried by each lane.
    typedef enum logic [2:0] {
        op_none,
        op_alu,
        op_load,
        op_store,
        op_fence
    } mem_op_t;

    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word
    } access_size_t;

endpackage
